// File: compile.f
hw/uart_pkg.sv
hw/uart_apb_regs.sv
hw/tx_fifo.sv
hw/baud_gen.sv
hw/tx_shifter.sv
hw/tx_ctrl.sv
hw/uart_tx_top.sv
sim/tx_ctrl_props.sv
sim/tb_uart_tx.sv

// File: hw/baud_gen.sv
// Baud prescaler and sub-tick counter producing one bit tick per OVERSAMPLE sub-ticks
`timescale 1ns/1ns

module baud_gen
  import uart_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  input  logic             baud_run,
  input  logic             clear,
  input  logic [DIV_W-1:0] divisor,
  output logic             bit_tick
);

  logic [DIV_W-1:0] pre_cnt;
  logic [3:0]       sub_cnt;
  logic             pre_wrap;

  // Greater-or-equal copes with a divisor lowered mid-count
  assign pre_wrap = (pre_cnt >= divisor - 1'b1);

  assign bit_tick = baud_run && pre_wrap && (sub_cnt == 4'(OVERSAMPLE-1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pre_cnt <= '0;
      sub_cnt <= '0;
    end else if (clear || !baud_run) begin
      pre_cnt <= '0;
      sub_cnt <= '0;
    end else if (pre_wrap) begin
      pre_cnt <= '0;
      // Rolls from 15 back to 0 on the bit tick
      sub_cnt <= sub_cnt + 1'b1;
    end else begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

endmodule

// File: hw/tx_ctrl.sv
// Transmitter FSM sequencing FIFO pop, frame load and start, data, parity and stop bits
`timescale 1ns/1ns

module tx_ctrl
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       enable,
  input  logic       parity_en,
  input  logic       empty,
  input  logic       bit_tick,
  input  logic [3:0] bits_left,
  output logic       pop,
  output logic       load,
  output logic       shift,
  output logic       baud_run,
  output logic       busy
);

  tx_state_e  state;
  tx_state_e  state_nxt;
  logic       fetch;
  logic       par_q;
  logic [3:0] frame_len;
  logic       last_data;

  // Frame format is frozen at load time
  assign frame_len = 4'(DATA_BITS + 2) + {3'b000, par_q};

  // Final data bit on the line when the start bit counts as the first of the frame
  assign last_data = (bits_left == frame_len - 4'(DATA_BITS));

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:   if (fetch) state_nxt = START;
      START:  if (bit_tick) state_nxt = DATA;
      DATA: begin
        if (bit_tick && last_data) begin
          state_nxt = par_q ? PARITY : STOP;
        end
      end
      PARITY: if (bit_tick) state_nxt = STOP;
      STOP:   if (bit_tick) state_nxt = DONE;
      DONE:   state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      fetch <= 1'b0;
      par_q <= 1'b0;
    end else begin
      state <= state_nxt;
      // Single fetch pulse when the next state is IDLE with a byte waiting
      fetch <= (state_nxt == IDLE) && enable && !empty;
      if (fetch) begin
        par_q <= parity_en;
      end
    end
  end

  // Head byte leaves the FIFO on the same edge it enters the shifter
  assign pop  = fetch;
  assign load = fetch;

  // Stop tick also shifts so bits_left ends at zero
  assign shift = bit_tick && (state inside {START, DATA, PARITY, STOP});

  assign baud_run = (state != IDLE);
  assign busy     = (state != IDLE);

endmodule

// File: hw/tx_fifo.sv
// Four-entry byte FIFO with occupancy count and full and empty flags
`timescale 1ns/1ns

module tx_fifo
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       push,
  input  logic [7:0] push_data,
  input  logic       pop,
  output logic [7:0] pop_data,
  output logic       full,
  output logic       empty
);

  logic [7:0]            mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;
  logic                  do_pop;

  // Pop on an empty FIFO is ignored
  assign do_pop = pop && !empty;

  assign empty    = (count == '0);
  assign full     = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
  assign pop_data = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hw/tx_shifter.sv
// Frame shift register with even parity generation and registered tx output
`timescale 1ns/1ns

module tx_shifter
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       load,
  input  logic       shift,
  input  logic [7:0] load_data,
  input  logic       parity_en,
  output logic       tx,
  output logic [3:0] bits_left
);

  // Bits queued behind tx: data, then parity or stop, then stop
  logic [DATA_BITS+1:0] frame_q;
  logic                 parity_bit;

  // Even parity
  assign parity_bit = ^load_data;

  always_ff @(posedge clk) begin
    if (load) begin
      frame_q <= {1'b1, (parity_en ? parity_bit : 1'b1), load_data};
    end else if (shift) begin
      // Ones fill in behind the frame
      frame_q <= {1'b1, frame_q[DATA_BITS+1:1]};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx        <= 1'b1;
      bits_left <= '0;
    end else if (load) begin
      // Start bit goes out right away
      tx        <= 1'b0;
      bits_left <= 4'(DATA_BITS + 2) + {3'b000, parity_en};
    end else if (shift) begin
      tx <= frame_q[0];
      if (bits_left != '0) begin
        bits_left <= bits_left - 1'b1;
      end
    end
  end

endmodule

// File: hw/uart_apb_regs.sv
// APB slave holding the CTRL, DIV and STATUS registers and turning DATA writes into FIFO pushes
`timescale 1ns/1ns

module uart_apb_regs
  import uart_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [3:0]       paddr,
  input  logic [31:0]      pwdata,
  input  logic             full,
  input  logic             empty,
  input  logic             busy,
  output logic [31:0]      prdata,
  output logic             pready,
  output logic             pslverr,
  output logic             enable,
  output logic             parity_en,
  output logic [DIV_W-1:0] divisor,
  output logic             push,
  output logic [7:0]       push_data
);

  reg_addr_e addr;
  logic      access;
  logic      wr_en;
  logic      mapped;
  logic      div_zero;
  logic      overflow;
  logic [31:0] rdata;

  assign addr     = reg_addr_e'(paddr);
  assign access   = psel && penable;
  assign div_zero = (pwdata[DIV_W-1:0] == '0);

  // Address decode and read mux
  always_comb begin
    mapped = 1'b1;
    rdata  = '0;
    case (addr)
      REG_CTRL:   rdata = {30'b0, parity_en, enable};
      REG_DIV:    rdata = {{(32-DIV_W){1'b0}}, divisor};
      REG_DATA:   rdata = '0;
      // Capacity field sits above the live flags
      REG_STATUS: rdata = {20'b0, 4'(FIFO_DEPTH), 4'b0, overflow, empty, full, busy};
      default:    mapped = 1'b0;
    endcase
  end

  // No wait states in a single clock domain
  assign pready  = 1'b1;
  assign pslverr = access && (!mapped || (pwrite && addr == REG_DIV && div_zero));
  assign prdata  = (access && !pwrite) ? rdata : '0;

  // Writes only land when the access is error free
  assign wr_en = access && pwrite && !pslverr;

  // Byte goes straight to the FIFO on the access edge
  assign push      = wr_en && (addr == REG_DATA) && !full;
  assign push_data = pwdata[7:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enable    <= 1'b0;
      parity_en <= 1'b0;
      divisor   <= DIV_W'(1);
      overflow  <= 1'b0;
    end else if (wr_en) begin
      case (addr)
        REG_CTRL: begin
          enable    <= pwdata[0];
          parity_en <= pwdata[1];
        end
        REG_DIV:    divisor <= pwdata[DIV_W-1:0];
        // Dropped byte marks the sticky overflow
        REG_DATA:   if (full) overflow <= 1'b1;
        // Write one to clear
        REG_STATUS: if (pwdata[3]) overflow <= 1'b0;
        default: ;
      endcase
    end
  end

endmodule

// File: hw/uart_pkg.sv
// Shared constants for the UART transmitter: FIFO sizing, bit timing, register map, FSM states
package uart_pkg;

  // Transmit FIFO geometry
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = 2;

  // Sub-ticks per serial bit
  localparam int OVERSAMPLE = 16;

  // Baud divisor register width
  localparam int DIV_W = 16;

  // Data bits per frame, always LSB first
  localparam int DATA_BITS = 8;

  // APB register offsets
  typedef enum logic [3:0] {
    REG_CTRL   = 4'h0,
    REG_DIV    = 4'h4,
    REG_DATA   = 4'h8,
    REG_STATUS = 4'hC
  } reg_addr_e;

  // Transmitter FSM states
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    START  = 3'd1,
    DATA   = 3'd2,
    PARITY = 3'd3,
    STOP   = 3'd4,
    DONE   = 3'd5
  } tx_state_e;

endpackage

// File: hw/uart_tx_top.sv
// UART transmitter top level joining APB registers, FIFO, FSM, baud generator and shifter
`timescale 1ns/1ns

module uart_tx_top
  import uart_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        tx
);

  // Register block outputs
  logic             enable;
  logic             parity_en;
  logic [DIV_W-1:0] divisor;
  logic             push;
  logic [7:0]       push_data;

  // FIFO status and head
  logic             full;
  logic             empty;
  logic [7:0]       pop_data;

  // FSM controls
  logic             pop;
  logic             load;
  logic             shift;
  logic             baud_run;
  logic             busy;

  // Datapath feedback
  logic             bit_tick;
  logic [3:0]       bits_left;

  uart_apb_regs u_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .full      (full),
    .empty     (empty),
    .busy      (busy),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .enable    (enable),
    .parity_en (parity_en),
    .divisor   (divisor),
    .push      (push),
    .push_data (push_data)
  );

  tx_fifo u_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty)
  );

  tx_ctrl u_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .enable    (enable),
    .parity_en (parity_en),
    .empty     (empty),
    .bit_tick  (bit_tick),
    .bits_left (bits_left),
    .pop       (pop),
    .load      (load),
    .shift     (shift),
    .baud_run  (baud_run),
    .busy      (busy)
  );

  // Load restarts the bit timing for each frame
  baud_gen u_baud (
    .clk      (clk),
    .arst_n   (arst_n),
    .baud_run (baud_run),
    .clear    (load),
    .divisor  (divisor),
    .bit_tick (bit_tick)
  );

  tx_shifter u_shift (
    .clk       (clk),
    .arst_n    (arst_n),
    .load      (load),
    .shift     (shift),
    .load_data (pop_data),
    .parity_en (parity_en),
    .tx        (tx),
    .bits_left (bits_left)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the UART transmitter testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_uart_tx -f compile.f -Mdir obj_dir -o sim_uart
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_uart > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Test failures found" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// File: sim/tb_uart_tx.sv
// UART transmitter testbench with clock, reset, APB tasks, serial decoder and test file playback
`timescale 1ns/1ns

module tb_uart_tx
  import uart_pkg::*;
();

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        tx;

  int          err_cnt;
  int          tmo_cnt;
  string       cur_name;
  int          div_shadow;
  logic        par_shadow;
  // Received frames as parity present, parity bit and data
  logic [9:0]  rx_q[$];

  uart_tx_top uut (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .tx      (tx)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] got);
    assert (got == exp) else begin
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", what, exp, got);
      err_cnt++;
    end
  endtask

  // One APB transfer with the result sampled late in the access cycle
  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                          output logic [31:0] rdata, output logic err);
    int guard;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2;
    guard = 0;
    while (!pready && guard < 100) begin
      @(posedge clk);
      #3;
      guard++;
    end
    if (!pready) begin
      $display("Timeout waiting for pready in %s", cur_name);
      tmo_cnt++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    if (wr && !err && addr == 4'h0) par_shadow = data[1];
    if (wr && !err && addr == 4'h4) div_shadow = int'(data[15:0]);
  endtask

  task automatic expect_byte(input logic [7:0] exp);
    int guard;
    logic [9:0] rec;
    guard = 0;
    while (rx_q.size() == 0 && guard < 20000) begin
      @(posedge clk);
      guard++;
    end
    if (rx_q.size() == 0) begin
      $display("Timeout waiting for a frame on tx in %s", cur_name);
      tmo_cnt++;
    end else begin
      rec = rx_q.pop_front();
      check_val(cur_name, {24'b0, exp}, {24'b0, rec[7:0]});
      if (rec[9]) check_val({cur_name, " parity"}, {31'b0, ^exp}, {31'b0, rec[8]});
    end
  endtask

  task automatic wait_idle();
    int guard;
    logic [31:0] rd;
    logic err;
    guard = 0;
    rd = '0;
    while (!(rd[0] == 1'b0 && rd[2] == 1'b1) && guard < 5000) begin
      apb_xfer(1'b0, 4'hC, '0, rd, err);
      guard++;
    end
    if (!(rd[0] == 1'b0 && rd[2] == 1'b1)) begin
      $display("Timeout waiting for the transmitter to go idle in %s", cur_name);
      tmo_cnt++;
    end
  endtask

  // Random bytes written as fast as the FIFO takes them and then checked in order
  task automatic send_random(input int count);
    logic [7:0] exp_q[$];
    logic [31:0] rd;
    logic err;
    logic [7:0] b;
    int guard;
    for (int i = 0; i < count; i++) begin
      guard = 0;
      rd = 32'h2;
      while (rd[1] && guard < 5000) begin
        apb_xfer(1'b0, 4'hC, '0, rd, err);
        guard++;
      end
      if (rd[1]) begin
        $display("Timeout waiting for FIFO space in %s", cur_name);
        tmo_cnt++;
      end
      b = 8'($urandom & 32'hFF);
      exp_q.push_back(b);
      apb_xfer(1'b1, 4'h8, {24'b0, b}, rd, err);
    end
    while (exp_q.size() > 0) begin
      expect_byte(exp_q.pop_front());
    end
  endtask

  task automatic run_step(input string op, input logic [31:0] addr, input logic [31:0] data,
                          input logic [31:0] exp);
    logic [31:0] rd;
    logic err;
    if (op == "write") begin
      apb_xfer(1'b1, addr[3:0], data, rd, err);
      check_val(cur_name, exp, {31'b0, err});
    end else if (op == "read") begin
      apb_xfer(1'b0, addr[3:0], '0, rd, err);
      check_val(cur_name, exp, rd);
    end else if (op == "send") begin
      apb_xfer(1'b1, 4'h8, data, rd, err);
      check_val(cur_name, 32'h0, {31'b0, err});
      expect_byte(exp[7:0]);
    end else if (op == "expect") begin
      expect_byte(exp[7:0]);
    end else if (op == "wait_idle") begin
      wait_idle();
    end else if (op == "tx_high") begin
      for (int i = 0; i < int'(data); i++) begin
        @(posedge clk);
        #2;
        check_val(cur_name, exp, {31'b0, tx});
      end
    end else if (op == "random") begin
      send_random(int'(data));
    end else begin
      $display("Unknown operation %s in step %s", op, cur_name);
      err_cnt++;
    end
  endtask

  // Serial decoder sampling mid bit and checking that edges fall on bit boundaries
  initial begin : decoder
    logic prev;
    logic use_par;
    logic done_f;
    logic [10:0] bits;
    int b_cyc;
    int nbits;
    int cnt;
    prev = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      if (arst_n && prev && !tx) begin
        b_cyc   = OVERSAMPLE * div_shadow;
        use_par = par_shadow;
        nbits   = use_par ? 11 : 10;
        bits    = '0;
        cnt     = 0;
        done_f  = 1'b0;
        while (!done_f) begin
          assert (tx == prev || (cnt % b_cyc) == 0) else begin
            $display("tx edge off a bit boundary in %s, %0d cycles into the frame",
                     cur_name, cnt);
            err_cnt++;
          end
          prev = tx;
          if ((cnt % b_cyc) == b_cyc / 2) begin
            bits[cnt / b_cyc] = tx;
            if (cnt / b_cyc == nbits - 1) done_f = 1'b1;
          end
          if (!done_f) begin
            @(posedge clk);
            #2;
            cnt++;
          end
        end
        check_val({cur_name, " start bit"}, 32'h0, {31'b0, bits[0]});
        check_val({cur_name, " stop bit"}, 32'h1, {31'b0, bits[nbits-1]});
        rx_q.push_back({use_par, use_par ? bits[9] : 1'b0, bits[8:1]});
      end
      prev = tx;
    end
  end

  initial begin : main
    int fd;
    int n;
    string line;
    string name;
    string op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    void'($urandom(32'he62f_23f0));
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    err_cnt    = 0;
    tmo_cnt    = 0;
    div_shadow = 1;
    par_shadow = 1'b0;
    cur_name   = "reset";
    arst_n     = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    fd = $fopen("sim/uart_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      err_cnt++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 3 || line[0] == "#") continue;
        n = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, exp);
        if (n != 5) continue;
        cur_name = name;
        run_step(op, addr, data, exp);
      end
      $fclose(fd);
    end
    repeat (4) @(posedge clk);
    $display("Errors: %0d failed checks, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: sim/tx_ctrl_props.sv
// Concurrent assertions on the transmitter FSM bound into the UART top level
`timescale 1ns/1ns

module tx_ctrl_props
  import uart_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input tx_state_e state,
  input logic      pop,
  input logic      busy,
  input logic      load,
  input logic      shift,
  input logic      tx
);

  // State register never leaves the encoded set
  a_legal_state: assert property (@(posedge clk) disable iff (!arst_n)
    state inside {IDLE, START, DATA, PARITY, STOP, DONE})
    else $error("tx_ctrl state left the legal encodings");

  a_pop_idle: assert property (@(posedge clk) disable iff (!arst_n)
    pop |-> (state == IDLE))
    else $error("FIFO pop issued outside IDLE");

  // busy only goes high with a frame load
  a_busy_rise: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(busy) |-> $past(load))
    else $error("busy rose without a frame load");

  // busy only drops when DONE hands back to IDLE
  a_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(busy) |-> ($past(state) == DONE))
    else $error("busy fell outside the end of DONE");

  // Line idles high between frames
  a_tx_idle: assert property (@(posedge clk) disable iff (!arst_n)
    (state == IDLE) |-> tx)
    else $error("tx low while the FSM is in IDLE");

  a_tx_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (!load && !shift) |=> $stable(tx))
    else $error("tx changed without a load or shift");

endmodule

// FSM state comes through the controller instance and the rest are top level nets
bind uart_tx_top tx_ctrl_props u_props (
  .clk    (clk),
  .arst_n (arst_n),
  .state  (u_ctrl.state),
  .pop    (pop),
  .busy   (busy),
  .load   (load),
  .shift  (shift),
  .tx     (tx)
);

// File: sim/uart_tests.txt
# name op addr data expected, numbers in hex
# write: expected pslverr, read: expected prdata, send/expect: expected byte
rst_status read c 0 404
rst_div read 4 0 1
rst_line tx_high 0 40 1
ctrl_wr write 0 3 0
ctrl_rd read 0 0 3
div_wr write 4 5 0
div_rd read 4 0 5
bad_addr write 2 ff 1
div_zero write 4 0 1
div_keep read 4 0 5
frame_cfg write 0 1 0
frame_div5 send 8 55 55
div_2 write 4 2 0
frame_div2 send 8 a3 a3
par_on write 0 3 0
par_a send 8 96 96
par_b send 8 07 07
burst_cfg write 0 1 0
burst_0 write 8 11 0
burst_1 write 8 22 0
burst_2 write 8 33 0
burst_3 write 8 44 0
burst_4 write 8 55 0
burst_drop write 8 66 0
ovf_set read c 0 40b
burst_rx0 expect 0 0 11
burst_rx1 expect 0 0 22
burst_rx2 expect 0 0 33
burst_rx3 expect 0 0 44
burst_rx4 expect 0 0 55
burst_idle wait_idle 0 0 0
ovf_clr write c 8 0
ovf_rd read c 0 404
hold_off write 0 0 0
hold_0 write 8 61 0
hold_1 write 8 62 0
hold_2 write 8 63 0
hold_status read c 0 400
hold_line tx_high 0 c8 1
hold_on write 0 1 0
hold_rx0 expect 0 0 61
hold_rx1 expect 0 0 62
hold_rx2 expect 0 0 63
hold_idle wait_idle 0 0 0
hold_done read c 0 404
rand_div write 4 1 0
rand_frames random 0 6 0
